/* filelist.f */
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_bus_master.sv
src/branch_predict.sv
src/return_addr_stack.sv
src/fetch_queue.sv
src/fetch_frontend.sv
testbench/fetch_frontend_chk.sv
testbench/tb_fetch_frontend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard src/*.sv) $(wildcard testbench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_fetch_frontend.sv */
/*
 * Testbench for the fetch frontend: Wishbone memory model, random ack delay
 * and back-pressure, and an in-order check of every delivered entry.
 * Redirects are raised with back-end ready low, and RAS flushes only come
 * together with a redirect, so the model RAS stays in step with the DUT.
 */
`timescale 1ns/1ns

module tb_fetch_frontend;

    localparam logic [31:0] BOOT       = 32'h0000_1000;
    localparam int          RAS_DEPTH  = 4;
    localparam int          WAIT_LIMIT = 4000;

    logic        clk_i = 1'b0;
    logic        rst_ni, flush_i, flush_bp_i, fetch_ready_i;
    logic        mispredict_i, eret_i, ex_valid_i, set_pc_commit_i;
    logic [31:0] mispredict_target_i, epc_i, trap_base_i, pc_commit_i;
    logic        wb_cyc_o, wb_stb_o, wb_ack_i = 1'b0;
    logic [31:0] wb_adr_o, wb_dat_i = '0;
    logic        fetch_valid_o, fetch_pred_o;
    logic [31:0] fetch_pc_o, fetch_instr_o;

    logic [31:0] prog_mem [logic [31:0]];
    logic [31:0] rnd_state = 32'he4672776;
    logic [31:0] model_pc = BOOT;
    logic [31:0] model_ras [$];
    int          delivered = 0;
    int          error_count = 0;
    int          stall_len = 0;
    int          ack_wait = 0;
    bit          ack_pending = 1'b0;
    bit          ready_val = 1'b1;
    bit          heavy_stall = 1'b0;
    string       test_name = "reset";

    fetch_frontend #(.ras_depth(RAS_DEPTH), .boot_addr(BOOT)) uut (.*);

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rnd_state = xorshift(rnd_state);
        r = rnd_state;
    endtask

    // op-imm filler, never control flow
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (prog_mem.exists(a)) begin
            return prog_mem[a];
        end
        return {a[31:7] ^ a[24:0], 7'h13};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, 7'h67};
    endfunction

    // expected {predicted, next pc}, updates the model RAS
    function automatic logic [32:0] predict_next(input logic [31:0] pc, input logic [31:0] w);
        logic [31:0] jimm, bimm, seq, top;
        logic        link_rd, link_rs1;
        jimm     = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        bimm     = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        seq      = pc + 32'd4;
        link_rd  = (w[11:7] == 5'd1) || (w[11:7] == 5'd5);
        link_rs1 = (w[19:15] == 5'd1) || (w[19:15] == 5'd5);
        if (w[6:0] == 7'h6f) begin
            if (link_rd) begin
                if (model_ras.size() == RAS_DEPTH) begin
                    void'(model_ras.pop_front());
                end
                model_ras.push_back(seq);
            end
            return {1'b1, pc + jimm};
        end
        if (w[6:0] == 7'h67 && w[14:12] == 3'b000) begin
            if (link_rd) begin
                if (model_ras.size() == RAS_DEPTH) begin
                    void'(model_ras.pop_front());
                end
                model_ras.push_back(seq);
            end else if (w[11:7] == 5'd0 && link_rs1 && model_ras.size() > 0) begin
                top = model_ras.pop_back();
                return {1'b1, top};
            end
            return {1'b0, seq};
        end
        if (w[6:0] == 7'h63 && w[31]) begin
            return {1'b1, pc + bimm};
        end
        return {1'b0, seq};
    endfunction

    // highest priority request wins
    function automatic logic [31:0] redirect_target();
        if (set_pc_commit_i) begin
            return pc_commit_i + 32'd4;
        end
        if (ex_valid_i) begin
            return trap_base_i;
        end
        if (eret_i) begin
            return epc_i;
        end
        return mispredict_target_i;
    endfunction

    task automatic fail_run();
        error_count++;
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
            fail_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // wishbone memory, 0 to 3 cycles of ack delay
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        logic [31:0] r;
        if (!rst_ni || wb_ack_i) begin
            wb_ack_i    = 1'b0;
            ack_pending = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!ack_pending) begin
                next_rand(r);
                ack_wait    = int'(r[1:0]);
                ack_pending = 1'b1;
            end
            if (ack_wait == 0) begin
                wb_ack_i = 1'b1;
                wb_dat_i = mem_word(wb_adr_o);
            end else begin
                ack_wait--;
            end
        end
    end

    // ------------------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        logic [32:0] nxt;
        if (rst_ni) begin
            if (fetch_valid_o && fetch_ready_i) begin
                check_value("pc", model_pc, fetch_pc_o);
                check_value("instr", mem_word(model_pc), fetch_instr_o);
                nxt = predict_next(model_pc, mem_word(model_pc));
                check_value("pred", {31'd0, nxt[32]}, {31'd0, fetch_pred_o});
                model_pc = nxt[31:0];
                delivered++;
            end
            if (flush_bp_i) begin
                model_ras.delete();
            end
            if (mispredict_i || eret_i || ex_valid_i || set_pc_commit_i) begin
                model_pc = redirect_target();
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic drive_cycle(input bit force_low);
        logic [31:0] r;
        @(negedge clk_i);
        if (stall_len == 0) begin
            next_rand(r);
            if (heavy_stall) begin
                ready_val = r[0];
                stall_len = ready_val ? int'(r[3:1]) + 1 : int'(r[8:4]) + 4;
            end else begin
                ready_val = r[1:0] != 2'b00;
                stall_len = int'(r[4:2]) + 1;
            end
        end
        stall_len--;
        fetch_ready_i = force_low ? 1'b0 : ready_val;
    endtask

    task automatic wait_deliveries(input int n);
        int target;
        int cycles;
        target = delivered + n;
        cycles = 0;
        while (delivered < target) begin
            drive_cycle(1'b0);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: no output entries in %s", test_name);
                fail_run();
            end
        end
    endtask

    task automatic raise_redirect(input bit mis, input bit er, input bit ex, input bit cm,
                                  input logic [31:0] base, input bit bp);
        drive_cycle(1'b1);
        mispredict_i        = mis;
        mispredict_target_i = base;
        eret_i              = er;
        epc_i               = base + 32'h100;
        ex_valid_i          = ex;
        trap_base_i         = base + 32'h200;
        set_pc_commit_i     = cm;
        pc_commit_i         = base + 32'h2fc;
        flush_bp_i          = bp;
        drive_cycle(1'b0);
        {mispredict_i, eret_i, ex_valid_i, set_pc_commit_i, flush_bp_i} = '0;
    endtask

    initial begin
        {rst_ni, flush_i, flush_bp_i, fetch_ready_i} = '0;
        {mispredict_i, eret_i, ex_valid_i, set_pc_commit_i} = '0;
        {mispredict_target_i, epc_i, trap_base_i, pc_commit_i} = '0;
        // forward beq, jal over a gap, then a backward bne loop
        prog_mem[32'h1010] = enc_branch(3'b000, 13'd8);
        prog_mem[32'h1014] = enc_jal(5'd0, 21'd12);
        prog_mem[32'h1028] = enc_branch(3'b001, 13'h1ff8);
        // call, return, second call into a self loop, then a bare return
        prog_mem[32'h2000] = enc_jal(5'd1, 21'h100);
        prog_mem[32'h2104] = enc_jalr(5'd0, 5'd1);
        prog_mem[32'h2004] = enc_jal(5'd1, 21'h1fc);
        prog_mem[32'h2200] = enc_jal(5'd0, 21'd0);
        prog_mem[32'h2204] = enc_jalr(5'd0, 5'd1);
        repeat (8) drive_cycle(1'b0);
        rst_ni = 1'b1;

        test_name = "straight_and_static";
        wait_deliveries(24);
        test_name = "call_return";
        raise_redirect(1'b1, 1'b0, 1'b0, 1'b0, 32'h2000, 1'b0);
        wait_deliveries(8);
        test_name = "ras_flush";
        raise_redirect(1'b1, 1'b0, 1'b0, 1'b0, 32'h2204, 1'b1);
        wait_deliveries(6);
        test_name = "mispredict";
        raise_redirect(1'b1, 1'b0, 1'b0, 1'b0, 32'h3000, 1'b1);
        wait_deliveries(4);
        test_name = "eret";
        raise_redirect(1'b0, 1'b1, 1'b0, 1'b0, 32'h5000, 1'b0);
        wait_deliveries(4);
        test_name = "exception";
        raise_redirect(1'b0, 1'b0, 1'b1, 1'b0, 32'h6000, 1'b0);
        wait_deliveries(4);
        test_name = "commit_flush";
        raise_redirect(1'b0, 1'b0, 1'b0, 1'b1, 32'h7000, 1'b0);
        wait_deliveries(4);
        test_name = "redirect_priority";
        raise_redirect(1'b1, 1'b1, 1'b1, 1'b1, 32'h8000, 1'b0);
        wait_deliveries(4);
        raise_redirect(1'b1, 1'b1, 1'b1, 1'b0, 32'h9000, 1'b0);
        wait_deliveries(4);
        // eret over mispredict
        raise_redirect(1'b1, 1'b1, 1'b0, 1'b0, 32'ha000, 1'b0);
        wait_deliveries(4);
        test_name = "back_pressure";
        heavy_stall = 1'b1;
        wait_deliveries(60);

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("TESTBENCH FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* testbench/fetch_frontend_chk.sv */
/*
 * Protocol assertions bound into the fetch frontend.
 * Output stability is not required across a redirect or flush, which empty
 * the queue.
 */
`timescale 1ns/1ns

module fetch_frontend_chk (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        redirect_i,
    input logic        flush_i,
    input logic        wb_cyc_o,
    input logic        wb_stb_o,
    input logic [31:0] wb_adr_o,
    input logic        wb_ack_i,
    input logic        fetch_valid_o,
    input logic        fetch_ready_i,
    input logic [31:0] fetch_pc_o,
    input logic [31:0] fetch_instr_o,
    input logic        fetch_pred_o
);

    stb_is_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_o == wb_cyc_o) else $error("stb differs from cyc");

    adr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_cyc_o && !wb_ack_i |=> $stable(wb_adr_o)) else $error("adr moved in a cycle");

    cyc_ends: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_cyc_o && wb_ack_i |=> !wb_cyc_o) else $error("cyc stayed high after ack");

    // held entry under back-pressure
    out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fetch_valid_o && !fetch_ready_i && !redirect_i && !flush_i |=>
        fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_instr_o)
        && $stable(fetch_pred_o)) else $error("output changed under back-pressure");

endmodule

bind fetch_frontend fetch_frontend_chk chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .redirect_i(redirect), .flush_i(flush_i),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_adr_o(wb_adr_o), .wb_ack_i(wb_ack_i),
    .fetch_valid_o(fetch_valid_o), .fetch_ready_i(fetch_ready_i),
    .fetch_pc_o(fetch_pc_o), .fetch_instr_o(fetch_instr_o), .fetch_pred_o(fetch_pred_o)
);

/* src/fetch_frontend.sv */
/*
 * Instruction fetch frontend for RV32I, uncompressed words only.
 * One Wishbone classic read at a time, with static prediction and a RAS.
 * boot_addr and ras_depth are fixed at elaboration.
 */
`timescale 1ns/1ns

module fetch_frontend #(
    parameter int unsigned                ras_depth = 4,
    parameter logic [fetch_pkg::XLEN-1:0] boot_addr = 32'h0000_1000
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      flush_bp_i,
    input  logic                      mispredict_i,
    input  logic [fetch_pkg::XLEN-1:0] mispredict_target_i,
    input  logic                      eret_i,
    input  logic [fetch_pkg::XLEN-1:0] epc_i,
    input  logic                      ex_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] trap_base_i,
    input  logic                      set_pc_commit_i,
    input  logic [fetch_pkg::XLEN-1:0] pc_commit_i,
    // wishbone classic, read only
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic [fetch_pkg::XLEN-1:0] wb_adr_o,
    input  logic [fetch_pkg::XLEN-1:0] wb_dat_i,
    input  logic                      wb_ack_i,
    // towards the back-end
    output logic                      fetch_valid_o,
    input  logic                      fetch_ready_i,
    output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
    output logic [fetch_pkg::XLEN-1:0] fetch_instr_o,
    output logic                      fetch_pred_o
);

    logic [fetch_pkg::XLEN-1:0] fetch_addr, rsp_addr, rsp_instr, pred_target;
    logic [fetch_pkg::XLEN-1:0] push_addr, ras_top;
    logic                       redirect, rsp_valid, pred_taken, queue_ready;
    logic                       push, pop, ras_valid;

    fetch_pc_gen #(.boot_addr(boot_addr)) i_pc_gen (
        .clk_i, .rst_ni, .mispredict_i, .mispredict_target_i, .eret_i, .epc_i,
        .ex_valid_i, .trap_base_i, .set_pc_commit_i, .pc_commit_i,
        .rsp_valid_i(rsp_valid), .rsp_addr_i(rsp_addr), .pred_taken_i(pred_taken),
        .pred_target_i(pred_target), .fetch_addr_o(fetch_addr), .redirect_o(redirect)
    );

    fetch_bus_master i_bus_master (
        .clk_i, .rst_ni, .fetch_addr_i(fetch_addr), .redirect_i(redirect),
        .queue_ready_i(queue_ready), .flush_i, .wb_dat_i, .wb_ack_i, .wb_cyc_o, .wb_stb_o,
        .wb_adr_o, .rsp_valid_o(rsp_valid), .rsp_addr_o(rsp_addr), .rsp_instr_o(rsp_instr)
    );

    branch_predict i_branch_predict (
        .rsp_valid_i(rsp_valid), .rsp_addr_i(rsp_addr), .rsp_instr_i(rsp_instr),
        .ras_valid_i(ras_valid), .ras_top_i(ras_top), .pred_taken_o(pred_taken),
        .pred_target_o(pred_target), .push_o(push), .push_addr_o(push_addr), .pop_o(pop)
    );

    // predictor state is flushed on its own request only
    return_addr_stack #(.depth(ras_depth)) i_ras (
        .clk_i, .rst_ni, .flush_i(flush_bp_i), .push_i(push), .push_addr_i(push_addr),
        .pop_i(pop), .valid_o(ras_valid), .top_o(ras_top)
    );

    fetch_queue i_fetch_queue (
        .clk_i, .rst_ni, .flush_i, .redirect_i(redirect), .wr_i(rsp_valid),
        .wr_pc_i(rsp_addr), .wr_instr_i(rsp_instr), .wr_pred_i(pred_taken),
        .rd_ready_i(fetch_ready_i), .ready_o(queue_ready), .valid_o(fetch_valid_o),
        .pc_o(fetch_pc_o), .instr_o(fetch_instr_o), .pred_o(fetch_pred_o)
    );

endmodule

/* src/fetch_queue.sv */
/*
 * Four-entry FIFO of fetch entries towards the back-end.
 * ready_o means not full. A flush or redirect empties it on the next edge,
 * and a write in that same cycle is dropped.
 */
`timescale 1ns/1ns

module fetch_queue (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      redirect_i,
    input  logic                      wr_i,
    input  logic [fetch_pkg::XLEN-1:0] wr_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] wr_instr_i,
    input  logic                      wr_pred_i,
    input  logic                      rd_ready_i,
    output logic                      ready_o,
    output logic                      valid_o,
    output logic [fetch_pkg::XLEN-1:0] pc_o,
    output logic [fetch_pkg::XLEN-1:0] instr_o,
    output logic                      pred_o
);

    localparam int unsigned DEPTH = 4;

    logic [fetch_pkg::XLEN-1:0] pc_q    [DEPTH];
    logic [fetch_pkg::XLEN-1:0] instr_q [DEPTH];
    logic [DEPTH-1:0]           pred_q;
    logic [1:0]                 wr_ptr_q, rd_ptr_q;
    logic [2:0]                 count_q;
    logic                       push, pop;

    assign push = wr_i & ready_o;
    assign pop  = valid_o & rd_ready_i;

    // pointers and fill level
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i || redirect_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + 2'(push);
            rd_ptr_q <= rd_ptr_q + 2'(pop);
            count_q  <= count_q + 3'(push) - 3'(pop);
        end
    end

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            pc_q[wr_ptr_q]    <= wr_pc_i;
            instr_q[wr_ptr_q] <= wr_instr_i;
            pred_q[wr_ptr_q]  <= wr_pred_i;
        end
    end

    assign ready_o = count_q != 3'(DEPTH);
    assign valid_o = count_q != '0;
    assign pc_o    = pc_q[rd_ptr_q];
    assign instr_o = instr_q[rd_ptr_q];
    assign pred_o  = pred_q[rd_ptr_q];

endmodule

/* src/return_addr_stack.sv */
/*
 * Circular return address stack, one valid bit per entry.
 * Overflow overwrites the oldest entry. A pop on an empty stack is ignored.
 * Push wins if push and pop arrive together.
 */
`timescale 1ns/1ns

module return_addr_stack #(
    parameter int unsigned depth = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      push_i,
    input  logic [fetch_pkg::XLEN-1:0] push_addr_i,
    input  logic                      pop_i,
    output logic                      valid_o,
    output logic [fetch_pkg::XLEN-1:0] top_o
);

    localparam int unsigned PTR_W = (depth > 1) ? $clog2(depth) : 1;

    logic [fetch_pkg::XLEN-1:0] addr_q [depth];
    logic [depth-1:0]           valid_q;
    logic [PTR_W-1:0]           ptr_q;      // index of the top entry
    logic [PTR_W-1:0]           ptr_inc, ptr_dec;

    // wrap by hand, depth need not be a power of two
    assign ptr_inc = (ptr_q == PTR_W'(depth-1)) ? '0 : ptr_q + 1'b1;
    assign ptr_dec = (ptr_q == '0) ? PTR_W'(depth-1) : ptr_q - 1'b1;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (push_i) begin
            ptr_q            <= ptr_inc;
            valid_q[ptr_inc] <= 1'b1;
        end else if (pop_i && valid_q[ptr_q]) begin
            valid_q[ptr_q] <= 1'b0;
            ptr_q          <= ptr_dec;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            addr_q[ptr_inc] <= push_addr_i;
        end
    end

    assign valid_o = valid_q[ptr_q];
    assign top_o   = addr_q[ptr_q];

endmodule

/* src/branch_predict.sv */
/*
 * Static prediction for one fetched RV32I word.
 * JAL is always taken, and branches are taken when their offset is negative.
 * Returns use the RAS. Any other JALR falls through sequentially.
 * Outputs are only active while rsp_valid_i is high.
 */
`timescale 1ns/1ns

module branch_predict (
    input  logic                      rsp_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] rsp_addr_i,
    input  logic [fetch_pkg::XLEN-1:0] rsp_instr_i,
    input  logic                      ras_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] ras_top_i,
    output logic                      pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o,
    output logic                      push_o,
    output logic [fetch_pkg::XLEN-1:0] push_addr_o,
    output logic                      pop_o
);

    fetch_pkg::instr_word_u     instr;
    logic                       is_jal, is_jalr, is_branch;
    logic                       rd_link, rs1_link;
    logic                       is_call, is_return;
    logic [fetch_pkg::XLEN-1:0] j_imm, b_imm;

    assign instr = rsp_instr_i;

    // ------------------------------------------------------------------------
    // control-flow decode
    // ------------------------------------------------------------------------
    assign is_jal    = instr.i_view.opcode == fetch_pkg::OPC_JAL;
    assign is_jalr   = (instr.i_view.opcode == fetch_pkg::OPC_JALR)
                     & (instr.i_view.funct3 == 3'b000);
    assign is_branch = instr.i_view.opcode == fetch_pkg::OPC_BRANCH;

    // ra or t0 marks a link
    assign rd_link  = (instr.i_view.rd == fetch_pkg::REG_RA)
                    | (instr.i_view.rd == fetch_pkg::REG_T0);
    assign rs1_link = (instr.i_view.rs1 == fetch_pkg::REG_RA)
                    | (instr.i_view.rs1 == fetch_pkg::REG_T0);

    assign is_call   = (is_jal | is_jalr) & rd_link;
    // jalr x0, 0(ra) style return
    assign is_return = is_jalr & (instr.i_view.rd == 5'd0) & rs1_link;

    // ------------------------------------------------------------------------
    // immediates, reassembled from the b/j view
    // ------------------------------------------------------------------------
    assign j_imm = {{(fetch_pkg::XLEN-21){instr.bj_view.sign}}, instr.bj_view.sign,
                    instr.bj_view.imm_19_12, instr.bj_view.imm_20,
                    instr.bj_view.imm_30_25, instr.bj_view.imm_24_21, 1'b0};

    // bit 7 of the word is imm[11], bits 11:8 are imm[4:1]
    assign b_imm = {{(fetch_pkg::XLEN-13){instr.bj_view.sign}}, instr.bj_view.sign,
                    instr.bj_view.rd[0], instr.bj_view.imm_30_25,
                    instr.bj_view.rd[4:1], 1'b0};

    // ------------------------------------------------------------------------
    // prediction
    // ------------------------------------------------------------------------
    always_comb begin
        pred_taken_o  = 1'b0;
        pred_target_o = rsp_addr_i + j_imm;
        if (rsp_valid_i) begin
            if (is_jal) begin
                pred_taken_o = 1'b1;
            end else if (is_branch && b_imm[fetch_pkg::XLEN-1]) begin
                // backward branch, assume a loop
                pred_taken_o  = 1'b1;
                pred_target_o = rsp_addr_i + b_imm;
            end else if (is_return && ras_valid_i) begin
                pred_taken_o  = 1'b1;
                pred_target_o = ras_top_i;
            end
        end
    end

    // ras requests, an empty stack gives no pop
    assign push_o      = rsp_valid_i & is_call;
    assign push_addr_o = rsp_addr_i + fetch_pkg::XLEN'(4);
    assign pop_o       = rsp_valid_i & is_return & ras_valid_i;

endmodule

/* src/fetch_bus_master.sv */
/*
 * Wishbone classic read master, one word per cycle, read only.
 * A classic cycle cannot be aborted. A request overtaken by a redirect or
 * flush still runs to its ack, and its data is then dropped.
 */
`timescale 1ns/1ns

module fetch_bus_master (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [fetch_pkg::XLEN-1:0] fetch_addr_i,
    input  logic                      redirect_i,
    input  logic                      queue_ready_i,
    input  logic                      flush_i,
    input  logic [fetch_pkg::XLEN-1:0] wb_dat_i,
    input  logic                      wb_ack_i,
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic [fetch_pkg::XLEN-1:0] wb_adr_o,
    output logic                      rsp_valid_o,
    output logic [fetch_pkg::XLEN-1:0] rsp_addr_o,
    output logic [fetch_pkg::XLEN-1:0] rsp_instr_o
);

    logic                      busy_q;
    logic                      kill_q;
    logic                      start;
    logic [fetch_pkg::XLEN-1:0] adr_q;

    // new read only with queue space and a settled pc
    assign start = ~busy_q & queue_ready_i & ~redirect_i & ~flush_i;

    // idle/busy of one read, plus kill for an overtaken request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            kill_q <= 1'b0;
        end else if (busy_q) begin
            if (wb_ack_i) begin
                busy_q <= 1'b0;
                kill_q <= 1'b0;
            end else if (redirect_i || flush_i) begin
                kill_q <= 1'b1;
            end
        end else if (start) begin
            busy_q <= 1'b1;
            kill_q <= 1'b0;
        end
    end

    // address held for the whole cycle
    always_ff @(posedge clk_i) begin
        if (start) begin
            adr_q <= fetch_addr_i;
        end
    end

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_adr_o = adr_q;

    // redirect on the ack cycle itself also drops the word
    assign rsp_valid_o = busy_q & wb_ack_i & ~kill_q & ~redirect_i & ~flush_i;
    assign rsp_addr_o  = adr_q;
    assign rsp_instr_o = wb_dat_i;

endmodule

/* src/fetch_pc_gen.sv */
/*
 * Next fetch PC with a fixed redirect priority.
 * The PC loads boot_addr on reset. Redirect targets are taken as given, with
 * no alignment applied. A commit flush resumes at pc_commit + 4.
 */
`timescale 1ns/1ns

module fetch_pc_gen #(
    parameter logic [fetch_pkg::XLEN-1:0] boot_addr = '0
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      mispredict_i,
    input  logic [fetch_pkg::XLEN-1:0] mispredict_target_i,
    input  logic                      eret_i,
    input  logic [fetch_pkg::XLEN-1:0] epc_i,
    input  logic                      ex_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] trap_base_i,
    input  logic                      set_pc_commit_i,
    input  logic [fetch_pkg::XLEN-1:0] pc_commit_i,
    input  logic                      rsp_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] rsp_addr_i,
    input  logic                      pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
    output logic [fetch_pkg::XLEN-1:0] fetch_addr_o,
    output logic                      redirect_o
);

    logic [fetch_pkg::XLEN-1:0] npc_d, npc_q;

    // any back-end request kills the request in flight
    assign redirect_o = mispredict_i | eret_i | ex_valid_i | set_pc_commit_i;

    // later assignments win, so the order below is lowest to highest priority
    always_comb begin
        npc_d = npc_q;
        // a response advances the pc, either to the prediction or sequentially
        if (rsp_valid_i) begin
            npc_d = pred_taken_i ? pred_target_i : rsp_addr_i + fetch_pkg::XLEN'(4);
        end
        if (mispredict_i) begin
            npc_d = mispredict_target_i;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_base_i;
        end
        // flush after a csr side effect, restart behind the committed insn
        if (set_pc_commit_i) begin
            npc_d = pc_commit_i + fetch_pkg::XLEN'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q <= boot_addr;
        end else begin
            npc_q <= npc_d;
        end
    end

    assign fetch_addr_o = npc_q;

endmodule

/* src/fetch_pkg.sv */
/*
 * Shared constants and the instruction-word view for the fetch frontend.
 * Only uncompressed RV32I words are described here. There are no RVC formats.
 * The B/J view keeps rd at bits 11:7, so branches read imm[4:1] and imm[11]
 * from that field.
 */
package fetch_pkg;

    // ------------------------------------------------------------------------
    // widths and encodings
    // ------------------------------------------------------------------------
    // address and instruction word width
    localparam int unsigned XLEN = 32;

    // major opcodes of the control-flow instructions
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // link registers, used to tell calls and returns apart
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

    // ------------------------------------------------------------------------
    // instruction word, decoded two ways
    // ------------------------------------------------------------------------
    // i-type layout: jalr target and link fields
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // b/j layout with the scattered immediate bits split out
    typedef struct packed {
        logic        sign;        // inst[31], sign of both immediates
        logic [5:0]  imm_30_25;   // imm[10:5] for b and j
        logic [3:0]  imm_24_21;   // imm[4:1] for j
        logic        imm_20;      // imm[11] for j
        logic [7:0]  imm_19_12;   // imm[19:12] for j
        logic [4:0]  rd;          // rd for j, {imm[4:1], imm[11]} for b
        logic [6:0]  opcode;
    } bj_type_t;

    typedef union packed {
        i_type_t  i_view;
        bj_type_t bj_view;
    } instr_word_u;

endpackage
